/* Bender.yml */
package:
  name: matchedFilter

sources:
  - verilog/mfPkg.sv
  - verilog/hilbertTransform.sv
  - verilog/coeffStore.sv
  - verilog/complexCorrelator.sv
  - verilog/matchedFilter.sv
  - target: test
    files:
      - verification/matchedFilter_chk.sv
      - verification/matchedFilterTb.sv

/* matchedFilter.f */
verilog/mfPkg.sv
verilog/hilbertTransform.sv
verilog/coeffStore.sv
verilog/complexCorrelator.sv
verilog/matchedFilter.sv
verification/matchedFilter_chk.sv
verification/matchedFilterTb.sv

/* verification/matchedFilterTb.sv */
module matchedFilterTb;
	timeunit 1ns;
	timeprecision 1ps;
	import mfPkg::*;

	localparam int tapCount = 8;
	localparam int minSpacing = tapCount + 12;  // Cycles between sample strobes
	localparam int resetCycles = 16;

	logic clock;
	logic rstN;
	logic coeffWriteValid;
	coeffWrite hostWrite;
	logic sampleValid;
	realSample sample;
	logic outValid;
	magnitude outMagnitude;

	longint recCode [$];           // Record kind with 0 for a write and 1 for a sample
	longint recA [$];
	longint recB [$];
	longint recC [$];
	magnitude expected [$];        // Magnitudes in sample order
	complexCoeff shadow [tapCount];  // Current host coefficients
	int outCount;
	int sampleCount;
	int writeCount;
	bit traceLoaded;
	logic [31:0] rngState;

	matchedFilter #(
		.tapCount (tapCount)
	) dut0 (
		.clock           (clock),
		.rstN            (rstN),
		.coeffWriteValid (coeffWriteValid),
		.coeffWrite      (hostWrite),
		.sampleValid     (sampleValid),
		.sample          (sample),
		.outValid        (outValid),
		.outMagnitude    (outMagnitude)
	);

	always #4 clock = ~clock;  // 8 ns period

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic int unsigned nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return {16'd0, rngState[31:16]};  // Upper bits are the better ones
	endfunction

	task automatic stopOnFailure(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped");
	endtask

	task automatic checkMagnitude(input magnitude got, input magnitude want);
		if (got !== want) begin
			$display("error: outMagnitude got %h expected %h", got, want);
			$display("ERRORS FOUND");
			$fatal(1, "magnitude mismatch");
		end
	endtask

	task automatic checkStrobe(input logic got, input logic want, input string name);
		if (got !== want) begin
			$display("error: %s got %h expected %h", name, got, want);
			$display("ERRORS FOUND");
			$fatal(1, "strobe mismatch");
		end
	endtask

	task automatic readTrace();
		int fd;
		int fields;
		string line;
		longint code;
		longint a;
		longint b;
		longint c;
		fd = $fopen("verification/matchedFilterTrace.txt", "r");
		if (fd == 0) begin
			stopOnFailure("the trace file could not be opened");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			fields = $sscanf(line, "%d %d %d %d", code, a, b, c);
			if (fields == 4) begin  // Comment lines do not scan
				recCode.push_back(code);
				recA.push_back(a);
				recB.push_back(b);
				recC.push_back(c);
				if (code == 1) begin
					expected.push_back(magnitude'(b));
					sampleCount++;
				end else begin
					writeCount++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic writeCoeff(input int address, input int re, input int im);
		@(posedge clock);
		coeffWriteValid <= 1'b1;
		hostWrite.address <= addressWidth'(address);
		hostWrite.value.re <= sampleWidth'(re);
		hostWrite.value.im <= sampleWidth'(im);
		@(posedge clock);
		coeffWriteValid <= 1'b0;
		if (address < tapCount) begin  // The store drops the rest
			shadow[address].re = sampleWidth'(re);
			shadow[address].im = sampleWidth'(im);
		end
	endtask

	// Rewrites an unchanged tap mid computation when asked to
	task automatic runSample(input int value, input bit rewrite);
		int target;
		int elapsed;
		int writeAt;
		int idleExtra;
		int address;
		target = outCount + 1;
		writeAt = rewrite ? 2 + int'(nextRandom() % 8) : -1;
		idleExtra = int'(nextRandom() % 8);
		@(posedge clock);
		sampleValid <= 1'b1;
		sample <= sampleWidth'(value);
		@(posedge clock);
		sampleValid <= 1'b0;
		elapsed = 1;
		while (outCount < target || elapsed < minSpacing + idleExtra) begin
			if (elapsed == writeAt) begin
				address = int'(nextRandom() % tapCount);
				coeffWriteValid <= 1'b1;
				hostWrite.address <= addressWidth'(address);
				hostWrite.value <= shadow[address];
			end else begin
				coeffWriteValid <= 1'b0;
			end
			@(posedge clock);
			elapsed++;
		end
		coeffWriteValid <= 1'b0;
		if (outCount != target) begin
			stopOnFailure("more than one output strobe arrived for one sample");
		end
	endtask

	//////////////////////////////////////////////////
	// Output monitor and watchdog
	//////////////////////////////////////////////////

	always @(negedge clock) begin
		if (rstN && outValid) begin
			if (outCount >= expected.size()) begin
				stopOnFailure("an output strobe arrived without a matching sample");
			end else begin
				checkMagnitude(outMagnitude, expected[outCount]);
				outCount++;
			end
		end
	end

	initial begin
		int limit;
		wait (traceLoaded);
		limit = (sampleCount + writeCount) * (tapCount + 20) + resetCycles + 8;
		repeat (limit) @(posedge clock);
		stopOnFailure("outputs stopped arriving before the trace was finished");
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		coeffWriteValid = 1'b0;
		hostWrite = '0;
		sampleValid = 1'b0;
		sample = '0;
		outCount = 0;
		sampleCount = 0;
		writeCount = 0;
		rngState = 32'h315d_8104;
		for (int k = 0; k < tapCount; k++) begin
			shadow[k] = '0;
		end
		readTrace();
		traceLoaded = 1'b1;
		repeat (resetCycles) @(posedge clock);
		rstN <= 1'b1;
		repeat (4) begin  // Quiet output after reset
			@(negedge clock);
			checkStrobe(outValid, 1'b0, "outValid");
			checkMagnitude(outMagnitude, '0);
		end
		for (int i = 0; i < recCode.size(); i++) begin
			if (recCode[i] == 0) begin
				writeCoeff(int'(recA[i]), int'(recB[i]), int'(recC[i]));
			end else begin
				runSample(int'(recA[i]), recC[i] != 0);
			end
		end
		repeat (minSpacing) @(posedge clock);  // Late stray strobes reach the monitor
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* verification/matchedFilterTrace.txt */
# code 0 is a coefficient write: address re im
# code 1 is a sample: value expectedMagnitude rewriteFlag
0 0 1 0
0 1 0 1
0 2 2 0
0 3 0 -2
0 4 1 1
0 5 0 0
0 6 -1 0
0 7 0 3
1 128 27 0
1 0 27 0
1 0 135 0
1 0 101 0
1 0 263 0
1 0 499 0
1 256 418 0
1 -128 243 1
1 384 243 0
1 0 439 1
0 0 2 -1
0 1 0 0
0 2 0 0
0 3 0 0
0 4 0 0
0 5 0 0
0 6 0 0
0 7 0 0
0 8 5 5
1 128 492 0
1 -256 1125 1
1 0 648 0
1 128 492 1

/* verification/matchedFilter_chk.sv */
module matchedFilter_chk (
	input logic clock,
	input logic rstN,
	input logic startStrobe,  // New analytic sample
	input logic busy,         // Correlator outside idle
	input logic writeStrobe,  // Host write
	input logic grant,
	input logic pulse         // Output strobe
);
	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////////////////////////
	// Protocol properties
	//////////////////////////////////////////////////

	// Samples must not arrive faster than one computation
	startWhileIdle: assert property (@(posedge clock) disable iff (!rstN)
		startStrobe |-> !busy)
		else $error("analytic sample arrived while the correlator was busy");

	// Host write wins the memory
	writeBlocksGrant: assert property (@(posedge clock) disable iff (!rstN)
		writeStrobe |-> !grant)
		else $error("read granted during a host write");

	singlePulse: assert property (@(posedge clock) disable iff (!rstN)
		pulse |=> !pulse)
		else $error("output strobe lasted more than one cycle");

endmodule

bind complexCorrelator matchedFilter_chk correlatorChk0 (
	.clock       (clock),
	.rstN        (rstN),
	.startStrobe (analyticValid),
	.busy        (state != mfPkg::idle),
	.writeStrobe (1'b0),
	.grant       (readGrant),
	.pulse       (outValid)
);

bind coeffStore matchedFilter_chk storeChk0 (
	.clock       (clock),
	.rstN        (rstN),
	.startStrobe (1'b0),
	.busy        (1'b0),
	.writeStrobe (coeffWriteValid),
	.grant       (readGrant),
	.pulse       (1'b0)
);

/* verilog/coeffStore.sv */
module coeffStore #(
	parameter int tapCount = 8
) (
	input logic clock,
	input logic rstN,
	input logic coeffWriteValid,
	input mfPkg::coeffWrite coeffWrite,
	input logic readRequest,
	input logic [mfPkg::addressWidth-1:0] readAddress,
	output logic readGrant,
	output mfPkg::complexCoeff readData
);
	import mfPkg::*;

	localparam int indexWidth = $clog2(tapCount);

	complexCoeff ram [tapCount];  // One entry per tap
	logic writeInRange;
	logic readInRange;

	//////////////////////////////////////////////////
	// Arbiter
	//////////////////////////////////////////////////

	// The host always wins, so a write in any cycle blocks the read
	always_comb begin
		readGrant = readRequest && !coeffWriteValid;
	end

	always_comb begin
		writeInRange = coeffWrite.address < tapCount;  // Writes past the end are dropped
		readInRange = readAddress < tapCount;
	end

	//////////////////////////////////////////////////
	// Coefficient RAM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < tapCount; k++) begin
				ram[k] <= '0;
			end
		end else if (coeffWriteValid && writeInRange) begin
			ram[coeffWrite.address[indexWidth-1:0]] <= coeffWrite.value;
		end
	end

	// Read data shows up the cycle after the grant
	always_ff @(posedge clock) begin
		if (readGrant) begin
			if (readInRange) begin
				readData <= ram[readAddress[indexWidth-1:0]];
			end else begin
				readData <= '0;
			end
		end
	end

endmodule

/* verilog/complexCorrelator.sv */
module complexCorrelator #(
	parameter int tapCount = 8
) (
	input logic clock,
	input logic rstN,
	input logic analyticValid,
	input mfPkg::analyticSample analytic,
	output logic readRequest,
	output logic [mfPkg::addressWidth-1:0] readAddress,
	input logic readGrant,
	input mfPkg::complexCoeff readData,
	output logic outValid,
	output mfPkg::magnitude outMagnitude
);
	import mfPkg::*;

	localparam int indexWidth = $clog2(tapCount);
	localparam int accWidth = magnitudeWidth - 1;  // Signed, so the L1 sum fits the output
	localparam logic [indexWidth-1:0] lastIndex = indexWidth'(tapCount - 1);

	correlatorState state;
	analyticSample delayLine [tapCount];    // Tap k holds the sample from k strobes ago
	logic [indexWidth-1:0] requestIndex;    // Tap being fetched
	logic [indexWidth-1:0] dataIndex;       // Tap that readData belongs to
	logic dataValid;                        // readData is fresh this cycle
	logic signed [accWidth-1:0] accRe;
	logic signed [accWidth-1:0] accIm;
	analyticSample tapSample;
	logic signed [accWidth-1:0] prodRR;
	logic signed [accWidth-1:0] prodII;
	logic signed [accWidth-1:0] prodIR;
	logic signed [accWidth-1:0] prodRI;
	logic [accWidth-1:0] absRe;
	logic [accWidth-1:0] absIm;

	function automatic logic [accWidth-1:0] absValue(input logic signed [accWidth-1:0] value);
		return (value < 0) ? -value : value;
	endfunction

	//////////////////////////////////////////////////
	// Delay line
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < tapCount; k++) begin
				delayLine[k] <= '0;
			end
		end else if (analyticValid) begin  // Shifts even while busy
			delayLine[0] <= analytic;
			for (int k = 1; k < tapCount; k++) begin
				delayLine[k] <= delayLine[k-1];
			end
		end
	end

	//////////////////////////////////////////////////
	// Multiply by the conjugate tap
	//////////////////////////////////////////////////

	// x * conj(h) = (xr*hr + xi*hi) + j(xi*hr - xr*hi)
	always_comb begin
		tapSample = delayLine[dataIndex];
		prodRR = $signed(tapSample.re) * $signed(readData.re);
		prodII = $signed(tapSample.im) * $signed(readData.im);
		prodIR = $signed(tapSample.im) * $signed(readData.re);
		prodRI = $signed(tapSample.re) * $signed(readData.im);
		absRe = absValue(accRe);
		absIm = absValue(accIm);
	end

	always_comb begin
		readRequest = state == fetch;
		readAddress = addressWidth'(requestIndex);
	end

	//////////////////////////////////////////////////
	// FSM and accumulators
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			requestIndex <= '0;
			dataIndex <= '0;
			dataValid <= 1'b0;
			accRe <= '0;
			accIm <= '0;
			outValid <= 1'b0;
			outMagnitude <= '0;
		end else begin
			outValid <= 1'b0;  // Single cycle strobe
			dataValid <= readGrant;
			dataIndex <= requestIndex;
			if (dataValid) begin
				accRe <= accRe + prodRR + prodII;
				accIm <= accIm + prodIR - prodRI;
			end
			case (state)
				idle: begin
					if (analyticValid) begin
						state <= fetch;
						requestIndex <= '0;
						accRe <= '0;
						accIm <= '0;
					end
				end
				fetch: begin
					if (readGrant) begin  // A denied read repeats next cycle
						if (requestIndex == lastIndex) begin
							state <= finish;
						end else begin
							requestIndex <= requestIndex + 1'b1;
						end
					end
				end
				finish: begin
					if (!dataValid) begin  // Last product is in the accumulators
						outValid <= 1'b1;
						outMagnitude <= magnitude'(absRe) + magnitude'(absIm);
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

/* verilog/hilbertTransform.sv */
module hilbertTransform (
	input logic clock,
	input logic rstN,
	input logic sampleValid,
	input mfPkg::realSample sample,
	output logic analyticValid,
	output mfPkg::analyticSample analytic
);
	import mfPkg::*;

	// Four 8 bit taps on a 16 bit sample need 24 bits, one spare
	localparam int sumWidth = sampleWidth + 9;

	realSample line [hilbertLength-1];  // Past samples, entry 0 is the newest
	realSample window [hilbertLength];  // Incoming sample followed by the line
	logic signed [sumWidth-1:0] tapSum;
	logic signed [sumWidth-1:0] scaledSum;

	//////////////////////////////////////////////////
	// Filter window and tap sum
	//////////////////////////////////////////////////

	always_comb begin
		window[0] = sample;  // The strobed sample joins the window directly
		for (int k = 1; k < hilbertLength; k++) begin
			window[k] = line[k-1];
		end
	end

	always_comb begin
		tapSum = '0;
		for (int k = 0; k < hilbertLength; k++) begin
			if (hilbertTaps[k] != 0) begin  // Even taps drop out
				tapSum = tapSum + sumWidth'(hilbertTaps[k] * window[k]);
			end
		end
		scaledSum = tapSum >>> hilbertShift;  // Remove the tap gain
	end

	//////////////////////////////////////////////////
	// Sample line and output register
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < hilbertLength - 1; k++) begin
				line[k] <= '0;
			end
			analyticValid <= 1'b0;
			analytic <= '0;
		end else begin
			analyticValid <= sampleValid;  // One cycle behind the input strobe
			if (sampleValid) begin
				line[0] <= sample;
				for (int k = 1; k < hilbertLength - 1; k++) begin
					line[k] <= line[k-1];
				end
				// Centre sample lines up with the filter delay
				analytic.re <= analyticWidth'(window[hilbertCentre]);
				analytic.im <= analyticWidth'(scaledSum);
			end
		end
	end

endmodule

/* verilog/matchedFilter.sv */
module matchedFilter #(
	parameter int tapCount = 8
) (
	input logic clock,
	input logic rstN,

	// Host coefficient writes
	input logic coeffWriteValid,
	input mfPkg::coeffWrite coeffWrite,

	// Real sample input
	input logic sampleValid,
	input mfPkg::realSample sample,

	// Correlation magnitude
	output logic outValid,
	output mfPkg::magnitude outMagnitude
);
	import mfPkg::*;

	// The tap index must fit the host address and the RAM stays small
	if (tapCount < 2 || tapCount > 64) begin : tapCountCheck
		$error("tapCount must lie between 2 and 64");
	end

	logic analyticValid;
	analyticSample analytic;
	logic readRequest;
	logic [addressWidth-1:0] readAddress;
	logic readGrant;
	complexCoeff readData;

	//////////////////////////////////////////////////
	// Real to analytic
	//////////////////////////////////////////////////

	hilbertTransform hilbert0 (
		.clock         (clock),
		.rstN          (rstN),
		.sampleValid   (sampleValid),
		.sample        (sample),
		.analyticValid (analyticValid),
		.analytic      (analytic)
	);

	//////////////////////////////////////////////////
	// Shared coefficient memory
	//////////////////////////////////////////////////

	coeffStore #(
		.tapCount (tapCount)
	) store0 (
		.clock           (clock),
		.rstN            (rstN),
		.coeffWriteValid (coeffWriteValid),
		.coeffWrite      (coeffWrite),
		.readRequest     (readRequest),
		.readAddress     (readAddress),
		.readGrant       (readGrant),
		.readData        (readData)
	);

	//////////////////////////////////////////////////
	// Correlation and magnitude
	//////////////////////////////////////////////////

	complexCorrelator #(
		.tapCount (tapCount)
	) correlator0 (
		.clock         (clock),
		.rstN          (rstN),
		.analyticValid (analyticValid),
		.analytic      (analytic),
		.readRequest   (readRequest),
		.readAddress   (readAddress),
		.readGrant     (readGrant),
		.readData      (readData),
		.outValid      (outValid),
		.outMagnitude  (outMagnitude)
	);

endmodule

/* verilog/mfPkg.sv */
package mfPkg;

	//////////////////////////////////////////////////
	// Sample and coefficient widths
	//////////////////////////////////////////////////

	localparam int sampleWidth = 16;                 // Real input and coefficient parts
	localparam int analyticWidth = sampleWidth + 2;  // Headroom for the Hilbert sum
	localparam int addressWidth = 8;                 // Tap index on the host bus
	localparam int magnitudeWidth = 48;              // L1 magnitude output

	typedef logic signed [sampleWidth-1:0] realSample;

	// One analytic sample, real part is the delayed centre sample
	typedef struct packed {
		logic signed [analyticWidth-1:0] re;
		logic signed [analyticWidth-1:0] im;  // Hilbert output
	} analyticSample;

	// One reference tap as stored in the coefficient RAM
	typedef struct packed {
		logic signed [sampleWidth-1:0] re;
		logic signed [sampleWidth-1:0] im;
	} complexCoeff;

	// Host write word
	typedef struct packed {
		logic [addressWidth-1:0] address;  // Tap index
		complexCoeff value;
	} coeffWrite;

	typedef logic [magnitudeWidth-1:0] magnitude;

	//////////////////////////////////////////////////
	// Hilbert filter constants
	//////////////////////////////////////////////////

	localparam int hilbertLength = 7;
	localparam int hilbertCentre = 3;  // Group delay in samples
	localparam int hilbertShift = 7;   // Taps carry a gain of 128

	// Odd taps follow 2/(pi*n), even taps are zero
	localparam int hilbertTaps [hilbertLength] = '{-27, 0, -81, 0, 81, 0, 27};

	//////////////////////////////////////////////////
	// FSM states
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		idle,    // Waiting for an analytic sample
		fetch,   // Reading taps from the coefficient store
		finish   // Draining the last product and emitting
	} correlatorState;

endpackage
